//--- vz_io.f
+incdir+include
design/vz_io_pkg.sv
design/key_matrix.sv
design/joystick_port.sv
design/keyboard_scan.sv
design/wb_io_slave.sv
design/vz_io_top.sv
sim/tb_clock_gen.sv
sim/vz_io_assertions.sv
sim/vz_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the vz_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vz_io.f --top-module vz_io_tb -o vz_io_sim

# Assertion errors are summed into the testbench report
./obj_dir/vz_io_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "run_sim: PASS"
else
	echo "run_sim: FAIL"
	exit 1
fi

//--- sim/vz_io_tb.sv
`timescale 1ns/1ps
`include "vz_io_config.svh"

module vz_io_tb;

	localparam int N_KEY = 200;
	localparam int N_COMBO = 56;	// 7 keys, 4 rows, with and without a letter
	localparam int N_LATCH = 40;
	localparam int N_SHRG = 40;
	localparam int N_JOY = 60;
	localparam int N_XFER = 1 + N_KEY + N_COMBO + N_LATCH + N_SHRG + N_JOY;
	localparam int WATCHDOG_NS = (N_XFER * 10 + 1000) * 20;

	logic CLK50MHZ, RESET_N;
	logic wb_cyc_i, wb_stb_i, wb_we_i, wb_tga_io_i, wb_ack_o;
	vz_io_pkg::addr_t wb_adr_i;
	vz_io_pkg::byte_t wb_dat_i, wb_dat_o;
	logic key_strobe_i, key_pressed_i, key_extended_i, cass_in_i, shrg_en_i;
	vz_io_pkg::scan_code_t key_code_i;
	vz_io_pkg::joy_t joy1_i, joy2_i;
	logic arm1_i, arm2_i;
	logic [1:0] speaker_o;
	logic cass_out_o, vdg_ag_o, vdg_css_o;
	vz_io_pkg::gfx_mode_t gfx_mode_o;

	// Reference model
	vz_io_pkg::key_matrix_t m_mat;
	vz_io_pkg::key_ex_t m_ex;
	vz_io_pkg::byte_t m_latch, m_shrg;

	integer seed = 32'h95b8_c2d6;
	int checks, errors, t_checks, t_errors, idx, i;
	logic [31:0] rnd, rnd2;
	vz_io_pkg::addr_t adr;
	vz_io_pkg::byte_t rd;

	vz_io_pkg::scan_code_t key_codes [15] = '{8'h1C, 8'h1B, 8'h2C, 8'h29, 8'h14, 8'h12,
		8'h3A, 8'h5A, 8'h59, 8'h75, 8'h6B, 8'h74, 8'h72, 8'h76, 8'h66};
	vz_io_pkg::scan_code_t ex_codes [7] = '{8'h59, 8'h75, 8'h6B, 8'h74, 8'h72, 8'h76, 8'h66};
	vz_io_pkg::scan_code_t letters [3] = '{8'h1C, 8'h3A, 8'h2C};	// A, M, T
	int rows [4] = '{1, 2, 4, 5};

	tb_clock_gen u_clock (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N));

	vz_io_top dut0 (.*);

	task automatic check_byte(input string name, input vz_io_pkg::byte_t got,
		input vz_io_pkg::byte_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error: %s = 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_mode(input string name, input vz_io_pkg::gfx_mode_t got,
		input vz_io_pkg::gfx_mode_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error: %s = 0x%01h, expected 0x%01h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// One classic transfer, called and left on a falling edge
	task automatic bus_cycle(input logic we, input logic io, input vz_io_pkg::addr_t a,
		input vz_io_pkg::byte_t wdat, output vz_io_pkg::byte_t rdat);
		int waited;
		waited = 0;
		rdat = 8'hFF;
		@(negedge CLK50MHZ);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_tga_io_i = io;
		wb_adr_i = a;
		wb_dat_i = wdat;
		do
		begin
			@(negedge CLK50MHZ);
			waited++;
		end
		while (!wb_ack_o && waited < 16);
		if (wb_ack_o)
			rdat = wb_dat_o;
		else
		begin
			errors++;
			$display("no ack from the slave within 16 cycles at address 0x%04h", a);
		end
		@(negedge CLK50MHZ);	// Stb drops in the cycle after ack
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// Only the keys of the test table
	function automatic void model_key(input vz_io_pkg::scan_code_t code, input logic pressed,
		input logic ext);
		case (code)
		8'h1C: m_mat[12] = ~pressed;	// A
		8'h1B: m_mat[9] = ~pressed;	// S
		8'h2C: m_mat[0] = ~pressed;	// T
		8'h29: m_mat[36] = ~pressed;	// Space
		8'h14: m_mat[10] = ~pressed;	// Ctrl
		8'h12: m_mat[18] = ~pressed;	// L-Shift
		8'h3A: m_mat[37] = ~pressed;	// M
		8'h5A: m_mat[50] = ~pressed;	// Return
		8'h59: m_ex[0] = ~pressed;
		8'h11: m_ex[ext ? 2 : 1] = ~pressed;
		8'h76: m_ex[3] = ~pressed;
		8'h75: m_ex[4] = ~pressed;
		8'h6B: m_ex[5] = ~pressed;
		8'h74: m_ex[6] = ~pressed;
		8'h72: m_ex[7] = ~pressed;
		8'h66: m_ex[8] = ~pressed;
		default:
		begin
		end
		endcase
	endfunction

	task automatic key_event(input vz_io_pkg::scan_code_t code, input logic pressed,
		input logic ext);
		key_code_i = code;
		key_pressed_i = pressed;
		key_extended_i = ext;
		key_strobe_i = 1'b1;
		@(negedge CLK50MHZ);
		key_strobe_i = 1'b0;
		model_key(code, pressed, ext);
	endtask

	function automatic vz_io_pkg::byte_t kb_expect(input vz_io_pkg::byte_t row_sel);
		vz_io_pkg::key_matrix_t e;
		vz_io_pkg::byte_t b;
		int r;
		e = m_mat;
		e[8*4+5] = m_mat[8*4+5] & m_ex[5] & m_ex[8];
		e[8*4+4] = m_mat[8*4+4] & m_ex[7];
		e[8*4+3] = m_mat[8*4+3] & m_ex[6];
		e[8*4+1] = m_mat[8*4+1] & m_ex[4];
		e[8*5+2] = m_mat[8*5+2] & m_ex[3];
		e[8*2+2] = m_mat[8*2+2] & m_ex[0];
		e[8*1+2] = m_mat[8*1+2] & (&m_ex[8:3]);
		b = 8'hFF;
		b[6] = ~cass_in_i;
		for (r = 0; r < `KB_ROWS; r++)
			if (!row_sel[r])
				b[5:0] = b[5:0] & e[8*r +: 6];
		return b;
	endfunction

	function automatic vz_io_pkg::byte_t joy_expect(input vz_io_pkg::byte_t port);
		vz_io_pkg::byte_t b;
		b = 8'hFF;
		if (port[7:4] != `JOY_PORT_NIBBLE)
			return b;
		if (!port[0])
			b = b & {3'b111, ~joy1_i};
		if (!port[1])
			b = b & {3'b111, ~arm1_i, 4'hF};
		if (!port[2])
			b = b & {3'b111, ~joy2_i};
		if (!port[3])
			b = b & {3'b111, ~arm2_i, 4'hF};
		return b;
	endfunction

	task automatic read_rows();
		vz_io_pkg::byte_t s;
		vz_io_pkg::byte_t r;
		int n;
		for (n = 0; n < 4; n++)
		begin
			s = 8'hFF;
			s[rows[n]] = 1'b0;
			bus_cycle(1'b0, 1'b0, {`VZ_IO_PAGE, 3'b000, s}, 8'h00, r);
			check_byte("wb_dat_o", r, kb_expect(s));
		end
	endtask

	task automatic check_outputs();
		check_bit("speaker_o[1]", speaker_o[1], m_latch[0]);
		check_bit("speaker_o[0]", speaker_o[0], m_latch[5]);
		check_bit("cass_out_o", cass_out_o, m_latch[2]);
		check_bit("vdg_ag_o", vdg_ag_o, m_latch[3]);
		check_bit("vdg_css_o", vdg_css_o, m_latch[4]);
	endtask

	task automatic end_test(input int n, input string name);
		$display("test %0d %s: %0d checks, %0d errors", n, name, checks - t_checks,
			errors - t_errors);
		t_checks = checks;
		t_errors = errors;
	endtask

	initial
	begin
		{wb_cyc_i, wb_stb_i, wb_we_i, wb_tga_io_i} = 4'b0000;
		wb_adr_i = '0;
		wb_dat_i = '0;
		{key_strobe_i, key_pressed_i, key_extended_i} = 3'b000;
		key_code_i = '0;
		{cass_in_i, shrg_en_i, arm1_i, arm2_i} = 4'b0000;
		joy1_i = '0;
		joy2_i = '0;
		{checks, errors, t_checks, t_errors} = {32'd0, 32'd0, 32'd0, 32'd0};
		m_mat = '1;
		m_ex = '1;
		m_latch = '0;
		m_shrg = `SHRG_RESET;
		@(negedge RESET_N);
		@(posedge RESET_N);

		rnd = $random(seed);
		cass_in_i = rnd[0];
		@(negedge CLK50MHZ);
		check_outputs();
		check_mode("gfx_mode_o", gfx_mode_o, 3'b010);
		bus_cycle(1'b0, 1'b0, 16'h68FE, 8'h00, rd);
		check_byte("wb_dat_o", rd, cass_in_i ? 8'hBF : 8'hFF);
		end_test(1, "reset values");

		for (i = 0; i < N_KEY; i++)
		begin
			rnd = $random(seed);
			idx = rnd[7:0] % 15;
			key_event(key_codes[idx], rnd[8], rnd[9]);
			cass_in_i = rnd[10];
			adr = {`VZ_IO_PAGE, rnd[26:16]};
			bus_cycle(1'b0, 1'b0, adr, 8'h00, rd);
			check_byte("wb_dat_o", rd, kb_expect(adr[7:0]));
		end
		end_test(2, "random keys");

		for (i = 0; i < 15; i++)
			key_event(key_codes[i], 1'b0, 1'b0);	// All keys up first
		for (i = 0; i < 7; i++)
		begin
			key_event(ex_codes[i], 1'b1, i >= 1 && i <= 4);	// Arrows carry E0
			read_rows();
			key_event(letters[i % 3], 1'b1, 1'b0);
			read_rows();
			key_event(letters[i % 3], 1'b0, 1'b0);
			key_event(ex_codes[i], 1'b0, i >= 1 && i <= 4);
		end
		end_test(3, "ctrl combinations");

		for (i = 0; i < N_LATCH; i++)
		begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			adr = rnd[0] ? {`VZ_IO_PAGE, rnd[11:1]} : rnd[31:16];
			bus_cycle(1'b1, rnd[12] & rnd[13], adr, rnd2[7:0], rd);
			if (!(rnd[12] & rnd[13]) && adr[15:11] == `VZ_IO_PAGE)
				m_latch = rnd2[7:0];
			check_outputs();
		end
		end_test(4, "output latch");

		for (i = 0; i < N_SHRG; i++)
		begin
			rnd = $random(seed);
			shrg_en_i = rnd[0];
			bus_cycle(1'b1, 1'b1, {rnd[15:8], `SHRG_PORT}, rnd[23:16], rd);
			if (rnd[0])
				m_shrg = rnd[23:16];
			check_mode("gfx_mode_o", gfx_mode_o, m_shrg[4:2]);
		end
		shrg_en_i = 1'b0;
		end_test(5, "shrg register");

		for (i = 0; i < N_JOY; i++)
		begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			joy1_i = rnd[4:0];
			joy2_i = rnd[9:5];
			arm1_i = rnd[10];
			arm2_i = rnd[11];
			repeat (3) @(negedge CLK50MHZ);	// Past the synchronizer
			adr = {rnd2[15:8], rnd2[16] ? {4'h2, rnd2[3:0]} : rnd2[7:0]};
			bus_cycle(1'b0, 1'b1, adr, 8'h00, rd);
			check_byte("wb_dat_o", rd, joy_expect(adr[7:0]));
		end
		end_test(6, "joystick ports");

		errors = errors + dut0.u_wb_io_slave.u_assertions.fail_count;
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog sized from the transfer count
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

endmodule

//--- sim/vz_io_assertions.sv
`timescale 1ns/1ps

module vz_io_assertions (
	input logic       CLK50MHZ,
	input logic       RESET_N,
	input logic       wb_cyc_i,
	input logic       wb_stb_i,
	input logic       wb_ack_i,
	input logic [1:0] speaker_i,
	input logic       cass_out_i,
	input logic       vdg_ag_i,
	input logic       vdg_css_i
);

	int fail_count = 0;	// Summed into the testbench error count

	ack_with_req: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
	else
	begin
		fail_count++;
		$error("ack while cyc or stb is low");
	end

	ack_single: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		wb_ack_i |=> !wb_ack_i)
	else
	begin
		fail_count++;
		$error("ack high in two consecutive cycles");
	end

	// No wait states, so ack follows a new request by one cycle
	ack_latency: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$rose(wb_cyc_i && wb_stb_i) |=> wb_ack_i)
	else
	begin
		fail_count++;
		$error("ack missing one cycle after request");
	end

	latch_in_reset: assert property (@(posedge CLK50MHZ)
		!RESET_N |-> (speaker_i == 2'b00 && !cass_out_i && !vdg_ag_i && !vdg_css_i))
	else
	begin
		fail_count++;
		$error("latch outputs not zero during reset");
	end

endmodule

bind wb_io_slave vz_io_assertions u_assertions (
	.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
	.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o),
	.speaker_i(speaker_o), .cass_out_i(cass_out_o),
	.vdg_ag_i(vdg_ag_o), .vdg_css_i(vdg_css_o)
);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic CLK50MHZ,
	output logic RESET_N
);

	initial
	begin
		CLK50MHZ = 1'b0;
		forever #(PERIOD_NS / 2) CLK50MHZ = ~CLK50MHZ;
	end

	// Starts high so the drop is a real falling edge for the async reset
	initial
	begin
		RESET_N = 1'b1;
		#(PERIOD_NS / 4);
		RESET_N = 1'b0;
		#(3 * PERIOD_NS - PERIOD_NS / 4);	// Three rising edges in reset
		RESET_N = 1'b1;
	end

endmodule

//--- design/vz_io_top.sv
`timescale 1ns/1ps

module vz_io_top (
	input  logic                 CLK50MHZ,
	input  logic                 RESET_N,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  vz_io_pkg::addr_t     wb_adr_i,
	input  vz_io_pkg::byte_t     wb_dat_i,
	input  logic                 wb_tga_io_i,
	output logic                 wb_ack_o,
	output vz_io_pkg::byte_t     wb_dat_o,
	input  logic                 key_strobe_i,
	input  logic                 key_pressed_i,
	input  logic                 key_extended_i,
	input  vz_io_pkg::scan_code_t key_code_i,
	input  logic                 cass_in_i,
	input  logic                 shrg_en_i,
	input  vz_io_pkg::joy_t      joy1_i,
	input  vz_io_pkg::joy_t      joy2_i,
	input  logic                 arm1_i,
	input  logic                 arm2_i,
	output logic [1:0]           speaker_o,
	output logic                 cass_out_o,
	output logic                 vdg_ag_o,
	output logic                 vdg_css_o,
	output vz_io_pkg::gfx_mode_t gfx_mode_o
);

	vz_io_pkg::key_matrix_t key_matrix;
	vz_io_pkg::key_ex_t key_ex;
	vz_io_pkg::byte_t kb_byte;
	vz_io_pkg::byte_t joy_byte;

	key_matrix u_key_matrix (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i), .key_pressed_i(key_pressed_i),
		.key_extended_i(key_extended_i), .key_code_i(key_code_i),
		.key_matrix_o(key_matrix), .key_ex_o(key_ex)
	);

	// Low address byte selects keyboard rows
	keyboard_scan u_keyboard_scan (
		.key_matrix_i(key_matrix), .key_ex_i(key_ex),
		.row_sel_i(wb_adr_i[7:0]), .cass_in_i(cass_in_i),
		.kb_byte_o(kb_byte)
	);

	joystick_port u_joystick_port (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.joy1_i(joy1_i), .joy2_i(joy2_i), .arm1_i(arm1_i), .arm2_i(arm2_i),
		.port_i(wb_adr_i[7:0]), .joy_byte_o(joy_byte)
	);

	wb_io_slave u_wb_io_slave (
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_tga_io_i(wb_tga_io_i),
		.wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
		.kb_byte_i(kb_byte), .joy_byte_i(joy_byte), .shrg_en_i(shrg_en_i),
		.speaker_o(speaker_o), .cass_out_o(cass_out_o),
		.vdg_ag_o(vdg_ag_o), .vdg_css_o(vdg_css_o), .gfx_mode_o(gfx_mode_o)
	);

endmodule

//--- design/wb_io_slave.sv
`timescale 1ns/1ps
`include "vz_io_config.svh"

module wb_io_slave (
	input  logic                CLK50MHZ,
	input  logic                RESET_N,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  vz_io_pkg::addr_t    wb_adr_i,
	input  vz_io_pkg::byte_t    wb_dat_i,
	input  logic                wb_tga_io_i,
	output logic                wb_ack_o,
	output vz_io_pkg::byte_t    wb_dat_o,
	input  vz_io_pkg::byte_t    kb_byte_i,
	input  vz_io_pkg::byte_t    joy_byte_i,
	input  logic                shrg_en_i,
	output logic [1:0]          speaker_o,
	output logic                cass_out_o,
	output logic                vdg_ag_o,
	output logic                vdg_css_o,
	output vz_io_pkg::gfx_mode_t gfx_mode_o
);

	vz_io_pkg::slave_state_t state_q;
	vz_io_pkg::byte_t latch_q;
	vz_io_pkg::byte_t shrg_q;
	logic req;
	logic page_hit;
	logic joy_hit;
	logic shrg_hit;

	// New transfer only from idle, so each request acks once
	assign req = wb_cyc_i & wb_stb_i & (state_q == vz_io_pkg::st_idle);

	assign page_hit = ~wb_tga_io_i & (wb_adr_i[15:11] == `VZ_IO_PAGE);
	assign joy_hit = wb_tga_io_i & (wb_adr_i[7:4] == `JOY_PORT_NIBBLE);
	assign shrg_hit = wb_tga_io_i & (wb_adr_i[7:0] == `SHRG_PORT);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state_q <= vz_io_pkg::st_idle;
			latch_q <= '0;
			shrg_q <= `SHRG_RESET;
		end
		else
		begin
			case (state_q)
			vz_io_pkg::st_idle: if (req) state_q <= vz_io_pkg::st_ack;
			default: state_q <= vz_io_pkg::st_idle;	// Ack lasts one cycle
			endcase

			// Writes land on the edge that raises ack
			if (req && wb_we_i && page_hit)
				latch_q <= wb_dat_i;
			if (req && wb_we_i && shrg_hit && shrg_en_i)
				shrg_q <= wb_dat_i;
		end
	end

	always_ff @(posedge CLK50MHZ)
	begin
		if (req && !wb_we_i)
		begin
			if (page_hit)
				wb_dat_o <= kb_byte_i;
			else if (joy_hit)
				wb_dat_o <= joy_byte_i;
			else
				wb_dat_o <= 8'hFF;	// Nothing decoded
		end
	end

	assign wb_ack_o = (state_q == vz_io_pkg::st_ack);

	assign speaker_o = {latch_q[0], latch_q[5]};	// Two speaker drive bits
	assign cass_out_o = latch_q[2];
	assign vdg_ag_o = latch_q[3];	// Graphics mode select
	assign vdg_css_o = latch_q[4];
	assign gfx_mode_o = shrg_q[4:2];

endmodule

//--- design/keyboard_scan.sv
`timescale 1ns/1ps
`include "vz_io_config.svh"

module keyboard_scan (
	input  vz_io_pkg::key_matrix_t key_matrix_i,
	input  vz_io_pkg::key_ex_t     key_ex_i,
	input  vz_io_pkg::byte_t       row_sel_i,
	input  logic                   cass_in_i,
	output vz_io_pkg::byte_t       kb_byte_o
);

	vz_io_pkg::key_matrix_t eff;
	logic [5:0] col;

	// Extra keys show up as Ctrl combinations
	always_comb
	begin
		eff = key_matrix_i;
		eff[37] = key_matrix_i[37] & key_ex_i[5] & key_ex_i[8];	// M by left or Backspace
		eff[36] = key_matrix_i[36] & key_ex_i[7];	// Space by down
		eff[35] = key_matrix_i[35] & key_ex_i[6];	// Comma by right
		eff[33] = key_matrix_i[33] & key_ex_i[4];	// Period by up
		eff[42] = key_matrix_i[42] & key_ex_i[3];	// Minus by Esc
		eff[18] = key_matrix_i[18] & key_ex_i[0];	// Both Shifts share a key

		// Any of Esc, arrows or Backspace also holds Ctrl
		eff[10] = key_matrix_i[10] & (&key_ex_i[8:3]);
	end

	// A column reads 0 if any selected row has that key down
	always_comb
	begin
		col = '1;
		for (int r = 0; r < `KB_ROWS; r++)
		begin
			for (int c = 0; c < 6; c++)
			begin
				if (!row_sel_i[r])
					col[c] = col[c] & eff[8*r+c];
			end
		end
	end

	assign kb_byte_o = {1'b1, ~cass_in_i, col};	// Bit 6 is cassette in, inverted

endmodule

//--- design/joystick_port.sv
`timescale 1ns/1ps

module joystick_port (
	input  logic             CLK50MHZ,
	input  logic             RESET_N,
	input  vz_io_pkg::joy_t  joy1_i,
	input  vz_io_pkg::joy_t  joy2_i,
	input  logic             arm1_i,
	input  logic             arm2_i,
	input  vz_io_pkg::byte_t port_i,
	output vz_io_pkg::byte_t joy_byte_o
);

	logic [11:0] meta_q;
	logic [11:0] sync_q;
	vz_io_pkg::byte_t byte_1a;
	vz_io_pkg::byte_t byte_1b;
	vz_io_pkg::byte_t byte_2a;
	vz_io_pkg::byte_t byte_2b;

	// Unselected byte reads as all ones
	function automatic vz_io_pkg::byte_t sel_byte(input logic sel_n, input vz_io_pkg::byte_t b);
		sel_byte = sel_n ? 8'hFF : b;
	endfunction

	// Buttons are asynchronous to the bus clock
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			meta_q <= '0;
			sync_q <= '0;
		end
		else
		begin
			meta_q <= {arm2_i, joy2_i, arm1_i, joy1_i};
			sync_q <= meta_q;
		end
	end

	assign byte_1a = {3'b111, ~sync_q[4:0]};	// Fire, right, left, down, up
	assign byte_1b = {3'b111, ~sync_q[5], 4'b1111};	// Arm button
	assign byte_2a = {3'b111, ~sync_q[10:6]};
	assign byte_2b = {3'b111, ~sync_q[11], 4'b1111};

	assign joy_byte_o = sel_byte(port_i[0], byte_1a) & sel_byte(port_i[1], byte_1b)
		& sel_byte(port_i[2], byte_2a) & sel_byte(port_i[3], byte_2b);

endmodule

//--- design/key_matrix.sv
`timescale 1ns/1ps

module key_matrix (
	input  logic                    CLK50MHZ,
	input  logic                    RESET_N,
	input  logic                    key_strobe_i,
	input  logic                    key_pressed_i,
	input  logic                    key_extended_i,
	input  vz_io_pkg::scan_code_t   key_code_i,
	output vz_io_pkg::key_matrix_t  key_matrix_o,
	output vz_io_pkg::key_ex_t      key_ex_o
);

	logic key_up;

	assign key_up = ~key_pressed_i;	// Matrix is active low

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_matrix_o <= '1;	// All keys released
			key_ex_o <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
			// Number row
			8'h16: key_matrix_o[28] <= key_up;	// 1
			8'h1E: key_matrix_o[25] <= key_up;	// 2
			8'h26: key_matrix_o[27] <= key_up;	// 3
			8'h25: key_matrix_o[29] <= key_up;	// 4
			8'h2E: key_matrix_o[24] <= key_up;	// 5
			8'h36: key_matrix_o[40] <= key_up;	// 6
			8'h3D: key_matrix_o[45] <= key_up;	// 7
			8'h3E: key_matrix_o[43] <= key_up;	// 8
			8'h46: key_matrix_o[41] <= key_up;	// 9
			8'h45: key_matrix_o[44] <= key_up;	// 0
			8'h4E: key_matrix_o[42] <= key_up;	// Minus
			// Letters
			8'h15: key_matrix_o[4] <= key_up;	// Q
			8'h1D: key_matrix_o[1] <= key_up;	// W
			8'h24: key_matrix_o[3] <= key_up;	// E
			8'h2D: key_matrix_o[5] <= key_up;	// R
			8'h2C: key_matrix_o[0] <= key_up;	// T
			8'h35: key_matrix_o[48] <= key_up;	// Y
			8'h3C: key_matrix_o[53] <= key_up;	// U
			8'h43: key_matrix_o[51] <= key_up;	// I
			8'h44: key_matrix_o[49] <= key_up;	// O
			8'h4D: key_matrix_o[52] <= key_up;	// P
			8'h1C: key_matrix_o[12] <= key_up;	// A
			8'h1B: key_matrix_o[9] <= key_up;	// S
			8'h23: key_matrix_o[11] <= key_up;	// D
			8'h2B: key_matrix_o[13] <= key_up;	// F
			8'h34: key_matrix_o[8] <= key_up;	// G
			8'h33: key_matrix_o[56] <= key_up;	// H
			8'h3B: key_matrix_o[61] <= key_up;	// J
			8'h42: key_matrix_o[59] <= key_up;	// K
			8'h4B: key_matrix_o[57] <= key_up;	// L
			8'h1A: key_matrix_o[20] <= key_up;	// Z
			8'h22: key_matrix_o[17] <= key_up;	// X
			8'h21: key_matrix_o[19] <= key_up;	// C
			8'h2A: key_matrix_o[21] <= key_up;	// V
			8'h32: key_matrix_o[16] <= key_up;	// B
			8'h31: key_matrix_o[32] <= key_up;	// N
			8'h3A: key_matrix_o[37] <= key_up;	// M
			// Punctuation and control
			8'h41: key_matrix_o[35] <= key_up;	// Comma
			8'h49: key_matrix_o[33] <= key_up;	// Period
			8'h4C: key_matrix_o[60] <= key_up;	// Semicolon
			8'h52: key_matrix_o[58] <= key_up;	// Quote maps to colon
			8'h29: key_matrix_o[36] <= key_up;	// Space
			8'h5A: key_matrix_o[50] <= key_up;	// Return
			8'h14: key_matrix_o[10] <= key_up;	// Either Ctrl
			8'h12: key_matrix_o[18] <= key_up;	// L-Shift
			// Keys with no matrix position of their own
			8'h59: key_ex_o[0] <= key_up;	// R-Shift
			8'h11:
			begin
				// Same code for both Alts, E0 prefix marks the right one
				if (key_extended_i)
					key_ex_o[2] <= key_up;
				else
					key_ex_o[1] <= key_up;
			end
			8'h76: key_ex_o[3] <= key_up;	// Esc
			8'h75: key_ex_o[4] <= key_up;	// Up
			8'h6B: key_ex_o[5] <= key_up;	// Left
			8'h74: key_ex_o[6] <= key_up;	// Right
			8'h72: key_ex_o[7] <= key_up;	// Down
			8'h66: key_ex_o[8] <= key_up;	// Backspace
			default:
			begin
			end
			endcase
		end
	end

endmodule

//--- design/vz_io_pkg.sv
`include "vz_io_config.svh"

package vz_io_pkg;

	// Bus address and data
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;

	// Row r in bits 8r..8r+5, bits 8r+6 and 8r+7 unused, 0 means pressed
	typedef logic [`KB_ROWS*8-1:0] key_matrix_t;

	// Extended keys, active low
	// 0 R-Shift, 1 left Alt, 2 right Alt, 3 Esc,
	// 4 up, 5 left, 6 right, 7 down, 8 Backspace, 9 spare
	typedef logic [9:0] key_ex_t;

	// PS/2 scan code
	typedef logic [7:0] scan_code_t;

	// Fire, right, left, down, up, active high
	typedef logic [4:0] joy_t;

	// SHRG mode bits to the video generator
	typedef logic [2:0] gfx_mode_t;

	// Bus slave handshake
	typedef enum logic
	{
		st_idle,
		st_ack
	} slave_state_t;

endpackage

//--- include/vz_io_config.svh
`ifndef VZ_IO_CONFIG_SVH
`define VZ_IO_CONFIG_SVH

// Address bits 15..11 of the keyboard and latch page, 6800-6FFF
`define VZ_IO_PAGE	5'b01101

// Joystick ports sit at I/O 20-2F
`define JOY_PORT_NIBBLE	4'h2

// SHRG graphics mode register
`define SHRG_PORT	8'd32
`define SHRG_RESET	8'h08	// Mode 010 after reset

// Keyboard matrix rows, one per low address bit
`define KB_ROWS	8

`endif
